// ==== rtl/nes_ctrl_defs.svh ====
`ifndef NES_CTRL_DEFS_SVH
`define NES_CTRL_DEFS_SVH

// decoded SPI slave bus
`define NC_ADDR_W       32
`define NC_DATA_W       8

// address pages, top byte of the SPI address
`define NC_PAGE_STATUS  8'hF1
`define NC_PAGE_RESET   8'hFF

// buttons and joypad
`define NC_BTN_W        7
`define NC_PAD_W        8
`define NC_DEBOUNCE_W   20

// start_n is active low, so idle has bit 0 set
`define NC_BTN_IDLE     7'h01

// audio
`define NC_SAMPLE_W     16
`define NC_AUDIO_W      4
`define NC_DITHER_W     12

`endif

// ==== rtl/nes_ctrl_pkg.sv ====
`default_nettype none

`include "nes_ctrl_defs.svh"

package nes_ctrl_pkg;

  // decoded bus from the SPI slave
  typedef struct packed {
    logic                  rd;
    logic                  wr;
    logic [`NC_ADDR_W-1:0] addr;
    logic [`NC_DATA_W-1:0] data;
  } spi_bus_t;

  // raw board levels as wired on the board
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic a;
    logic b;
    logic start_n; // active low
  } board_btn_t;

  // console pad order, all active high
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } pad_t;

  // one read byte, meaning depends on the page
  typedef union packed {
    struct packed {
      logic       irq;
      logic [6:0] rsvd;
    } status;
    struct packed {
      logic       pad;
      board_btn_t btn;
    } buttons;
  } spi_rdata_u;

  typedef struct packed {
    logic [`NC_DATA_W-1:0] data;
    logic [`NC_ADDR_W-1:0] addr;
  } load_t;

endpackage

`default_nettype wire

// ==== rtl/spi_reg_port.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "nes_ctrl_defs.svh"

module spi_reg_port
(
  input  wire                             clock,
  input  wire                             i_rst_n,
  input  wire nes_ctrl_pkg::spi_bus_t     i_spi,
  input  wire nes_ctrl_pkg::board_btn_t   i_held,
  input  wire                             i_irq,
  output logic                            o_load_valid,
  output nes_ctrl_pkg::load_t             o_load,
  output logic                            o_sys_reset,
  output nes_ctrl_pkg::spi_rdata_u        o_spi_rdata,
  output logic                            o_status_read_done
);

  localparam int PAGE_W = 8;

  logic                     rd_q;
  logic                     wr_q;
  logic [PAGE_W-1:0]        page;
  logic                     page_status;
  logic                     page_reset;
  nes_ctrl_pkg::spi_rdata_u rdata_next;

  assign page        = i_spi.addr[`NC_ADDR_W-1 -: PAGE_W];
  assign page_status = (page == `NC_PAGE_STATUS);
  assign page_reset  = (page == `NC_PAGE_RESET);

  // one pulse per write, on the first cycle of wr
  assign o_load_valid = i_spi.wr & ~wr_q;
  assign o_load.data  = i_spi.data;
  assign o_load.addr  = i_spi.addr;

  // falling rd on the status page clears the irq
  assign o_status_read_done = ~i_spi.rd & rd_q & page_status;

  always_comb
  begin
    rdata_next = '0;
    if (page_status)
    begin
      rdata_next.status.irq = i_irq;
    end
    else
    begin
      rdata_next.buttons.pad = 1'b0;
      rdata_next.buttons.btn = i_held;
    end
  end

  always_ff @(posedge clock or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      rd_q        <= 1'b0;
      wr_q        <= 1'b0;
      o_sys_reset <= 1'b0;
      o_spi_rdata <= '0;
    end
    else
    begin
      rd_q <= i_spi.rd;
      wr_q <= i_spi.wr;
      if (i_spi.wr && page_reset)
        o_sys_reset <= i_spi.data[0]; // system reset bit
      if (i_spi.rd)
        o_spi_rdata <= rdata_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/btn_irq_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "nes_ctrl_defs.svh"

module btn_irq_ctrl
#(
  parameter int OSD_SRC    = 2,              // 0 board, 1 usb, 2 both
  parameter int DEBOUNCE_W = `NC_DEBOUNCE_W
)
(
  input  wire                             clock,
  input  wire                             i_rst_n,
  input  wire nes_ctrl_pkg::board_btn_t   i_btn,
  input  wire nes_ctrl_pkg::pad_t         i_usb_btn,
  input  wire                             i_status_read_done,
  output nes_ctrl_pkg::board_btn_t        o_held,
  output logic                            o_irq,
  output logic                            o_irq_n
);

  nes_ctrl_pkg::board_btn_t usb_dir;
  nes_ctrl_pkg::board_btn_t merged;
  nes_ctrl_pkg::board_btn_t latch_q;
  nes_ctrl_pkg::board_btn_t held_q;
  logic [DEBOUNCE_W-1:0]    cnt_q;
  logic                     irq_q;
  logic                     settled;

  // USB contributes directions only with start_n held inactive
  always_comb
  begin
    usb_dir.right   = i_usb_btn.right;
    usb_dir.left    = i_usb_btn.left;
    usb_dir.down    = i_usb_btn.down;
    usb_dir.up      = i_usb_btn.up;
    usb_dir.a       = 1'b0;
    usb_dir.b       = 1'b0;
    usb_dir.start_n = 1'b1;
  end

  always_comb
  begin
    case (OSD_SRC)
      0:       merged = i_btn;
      1:       merged = usb_dir;
      default: merged = nes_ctrl_pkg::board_btn_t'(i_btn | usb_dir);
    endcase
  end

  assign settled = cnt_q[DEBOUNCE_W-1]; // debounce time elapsed

  always_ff @(posedge clock or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      latch_q <= `NC_BTN_IDLE;
      held_q  <= `NC_BTN_IDLE;
      cnt_q   <= '0;
      irq_q   <= 1'b0;
    end
    else if (i_status_read_done)
    begin
      irq_q <= 1'b0; // host has read the status
    end
    else
    begin
      latch_q <= merged;
      if (latch_q != held_q && settled && !irq_q)
      begin
        irq_q  <= 1'b1;
        cnt_q  <= '0;
        held_q <= latch_q;
      end
      else if (!settled)
      begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign o_held  = held_q;
  assign o_irq   = irq_q;
  assign o_irq_n = ~irq_q; // falling edge requests a read

endmodule

`default_nettype wire

// ==== rtl/joypad_serializer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "nes_ctrl_defs.svh"

module joypad_serializer
(
  input  wire                             clock,
  input  wire                             i_rst_n,
  input  wire nes_ctrl_pkg::board_btn_t   i_btn,
  input  wire nes_ctrl_pkg::pad_t         i_usb_btn,
  input  wire                             i_joy_strobe,
  input  wire                             i_joy_clock,
  output logic                            o_joy_data
);

  nes_ctrl_pkg::pad_t    board_pad;
  nes_ctrl_pkg::pad_t    board_pad_q;
  logic                  joy_clock_q;
  logic [`NC_PAD_W-1:0]  shift_q;

  // board wiring to console pad order
  always_comb
  begin
    board_pad.right  = i_btn.right;
    board_pad.left   = i_btn.left;
    board_pad.down   = i_btn.down;
    board_pad.up     = i_btn.up;
    board_pad.start  = ~i_btn.start_n;
    board_pad.select = 1'b0; // no spare button on the board
    board_pad.b      = i_btn.b;
    board_pad.a      = i_btn.a;
  end

  always_ff @(posedge clock or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      board_pad_q <= '0;
      joy_clock_q <= 1'b0;
      shift_q     <= '0;
    end
    else
    begin
      board_pad_q <= board_pad;
      joy_clock_q <= i_joy_clock;
      if (i_joy_strobe)
        shift_q <= board_pad_q | i_usb_btn; // parallel load
      else if (!i_joy_clock && joy_clock_q)
        shift_q <= {1'b0, shift_q[`NC_PAD_W-1:1]}; // next bit on falling edge
    end
  end

  assign o_joy_data = shift_q[0];

endmodule

`default_nettype wire

// ==== rtl/audio_dither_dac.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "nes_ctrl_defs.svh"

module audio_dither_dac
(
  input  wire                         clock,
  input  wire                         i_rst_n,
  input  wire [`NC_SAMPLE_W-1:0]      i_sample,
  output logic [`NC_AUDIO_W-1:0]      o_audio
);

  logic [`NC_DITHER_W:0]    acc_q;    // top bit is the registered carry
  logic [`NC_AUDIO_W-1:0]   nib_q;    // coarse level of the same sample
  logic [`NC_DITHER_W-1:0]  fine;
  logic [`NC_AUDIO_W-1:0]   nib;

  assign fine = i_sample[`NC_DITHER_W-1:0];
  assign nib  = i_sample[`NC_SAMPLE_W-1 -: `NC_AUDIO_W];

  // first order sigma-delta, carry rate equals fine/4096
  always_ff @(posedge clock or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      acc_q <= '0;
      nib_q <= '0;
    end
    else
    begin
      acc_q <= {1'b0, acc_q[`NC_DITHER_W-1:0]} + {1'b0, fine};
      nib_q <= nib;
    end
  end

  // step up one level on carry, wraps at 15
  always_comb
  begin
    if (acc_q[`NC_DITHER_W])
      o_audio = nib_q + 1'b1;
    else
      o_audio = nib_q;
  end

endmodule

`default_nettype wire

// ==== rtl/nes_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "nes_ctrl_defs.svh"

module nes_ctrl_top
#(
  parameter int OSD_SRC    = 2,
  parameter int DEBOUNCE_W = `NC_DEBOUNCE_W
)
(
  input  wire                             clock,
  input  wire                             i_rst_n,
  input  wire nes_ctrl_pkg::spi_bus_t     i_spi,
  input  wire nes_ctrl_pkg::board_btn_t   i_btn,
  input  wire nes_ctrl_pkg::pad_t         i_usb_btn,
  input  wire                             i_joy_strobe,
  input  wire                             i_joy_clock,
  input  wire [`NC_SAMPLE_W-1:0]          i_sample,
  output logic                            o_load_valid,
  output nes_ctrl_pkg::load_t             o_load,
  output logic                            o_sys_reset,
  output nes_ctrl_pkg::spi_rdata_u        o_spi_rdata,
  output logic                            o_irq_n,
  output logic                            o_joy_data,
  output logic [`NC_AUDIO_W-1:0]          o_audio
);

  nes_ctrl_pkg::board_btn_t held;
  logic                     irq;
  logic                     status_read_done;

  spi_reg_port u_spi_reg_port
  (
    .clock              (clock),
    .i_rst_n            (i_rst_n),
    .i_spi              (i_spi),
    .i_held             (held),
    .i_irq              (irq),
    .o_load_valid       (o_load_valid),
    .o_load             (o_load),
    .o_sys_reset        (o_sys_reset),
    .o_spi_rdata        (o_spi_rdata),
    .o_status_read_done (status_read_done)
  );

  btn_irq_ctrl
  #(
    .OSD_SRC    (OSD_SRC),
    .DEBOUNCE_W (DEBOUNCE_W)
  )
  u_btn_irq_ctrl
  (
    .clock              (clock),
    .i_rst_n            (i_rst_n),
    .i_btn              (i_btn),
    .i_usb_btn          (i_usb_btn),
    .i_status_read_done (status_read_done),
    .o_held             (held),
    .o_irq              (irq),
    .o_irq_n            (o_irq_n)
  );

  joypad_serializer u_joypad_serializer
  (
    .clock        (clock),
    .i_rst_n      (i_rst_n),
    .i_btn        (i_btn),
    .i_usb_btn    (i_usb_btn),
    .i_joy_strobe (i_joy_strobe),
    .i_joy_clock  (i_joy_clock),
    .o_joy_data   (o_joy_data)
  );

  audio_dither_dac u_audio_dither_dac
  (
    .clock    (clock),
    .i_rst_n  (i_rst_n),
    .i_sample (i_sample),
    .o_audio  (o_audio)
  );

endmodule

`default_nettype wire

// ==== tb/nes_ctrl_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "nes_ctrl_defs.svh"

module nes_ctrl_assertions
(
  input wire                        clock,
  input wire                        i_rst_n,
  input wire [`NC_SAMPLE_W-1:0]     i_sample,
  input wire                        o_load_valid,
  input wire                        o_irq_n,
  input wire [`NC_AUDIO_W-1:0]      o_audio,
  input wire                        status_read_done
);

  a_load_pulse: assert property (@(posedge clock) disable iff (!i_rst_n)
    o_load_valid |=> !o_load_valid)
    else $error("o_load_valid stayed high for two cycles");

  // irq never sets during a status clear
  a_irq_fall: assert property (@(posedge clock) disable iff (!i_rst_n)
    $fell(o_irq_n) |-> !$past(status_read_done))
    else $error("o_irq_n fell during a status clear");

  a_irq_rise: assert property (@(posedge clock) disable iff (!i_rst_n)
    $rose(o_irq_n) |-> $past(status_read_done))
    else $error("o_irq_n rose without a status read");

  a_audio_level: assert property (@(posedge clock) disable iff (!i_rst_n)
    (o_audio == $past(i_sample[`NC_SAMPLE_W-1 -: `NC_AUDIO_W])) ||
    (o_audio == $past(i_sample[`NC_SAMPLE_W-1 -: `NC_AUDIO_W]) + 1'b1)) // wraps in 4 bits
    else $error("o_audio left the two levels around the sample");

endmodule

bind nes_ctrl_top nes_ctrl_assertions u_assertions
(
  .clock            (clock),
  .i_rst_n          (i_rst_n),
  .i_sample         (i_sample),
  .o_load_valid     (o_load_valid),
  .o_irq_n          (o_irq_n),
  .o_audio          (o_audio),
  .status_read_done (status_read_done)
);

`default_nettype wire

// ==== tb/nes_ctrl_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "nes_ctrl_defs.svh"

module nes_ctrl_tb;

  logic                       clock;
  logic                       i_rst_n;
  nes_ctrl_pkg::spi_bus_t     i_spi;
  nes_ctrl_pkg::board_btn_t   i_btn;
  nes_ctrl_pkg::pad_t         i_usb_btn;
  logic                       i_joy_strobe;
  logic                       i_joy_clock;
  logic [`NC_SAMPLE_W-1:0]    i_sample;
  logic                       o_load_valid;
  nes_ctrl_pkg::load_t        o_load;
  logic                       o_sys_reset;
  nes_ctrl_pkg::spi_rdata_u   o_spi_rdata;
  logic                       o_irq_n;
  logic                       o_joy_data;
  logic [`NC_AUDIO_W-1:0]     o_audio;

  int          errors;
  int          timeouts;
  int          checks;
  logic [31:0] lfsr;

  nes_ctrl_top
  #(
    .OSD_SRC    (2),
    .DEBOUNCE_W (6)
  )
  uut
  (
    .*
  );

  always #2 clock = ~clock;

  // inputs change 1 ns after the rising edge
  task automatic step;
    @(posedge clock);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  // galois taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  task automatic idle_gap;
    int n;
    n = 0;
    repeat (2)
    begin
      lfsr = lfsr_next(lfsr);
      n    = (n << 1) | lfsr[0]; // one step per bit
    end
    repeat (n) step;
  endtask

  // usb gives directions only and leaves start_n released
  function automatic logic [6:0] merge_buttons(input logic [6:0] board, input logic [7:0] usb);
    return board | {usb[7:4], 3'b001};
  endfunction

  function automatic logic [7:0] board_to_pad(input logic [6:0] board, input logic [7:0] usb);
    return {board[6:3], ~board[0], 1'b0, board[1], board[2]} | usb;
  endfunction

  task automatic write_burst(input logic [31:0] addr, input logic [31:0] data,
                             input logic [31:0] exp_rst);
    int pulses;
    pulses     = 0;
    i_spi.wr   = 1'b1;
    i_spi.addr = addr;
    i_spi.data = data[7:0];
    for (int i = 0; i < 3; i++)
    begin
      #1;
      if (o_load_valid)
      begin
        pulses++;
        check_value("o_load.data", o_load.data, data);
        check_value("o_load.addr", o_load.addr, addr);
      end
      if (i == 1)
        check_value("o_sys_reset", o_sys_reset, exp_rst); // one cycle after the write
      step;
    end
    i_spi.wr = 1'b0;
    step;
    check_value("o_load_valid pulses", pulses, 1);
  endtask

  task automatic read_reg(input string name, input logic [7:0] page, input logic [7:0] exp);
    i_spi.rd   = 1'b1;
    i_spi.addr = {page, 24'h0};
    step;
    i_spi.rd = 1'b0; // read ends here
    #1;
    check_value(name, o_spi_rdata, exp);
    step;
  endtask

  task automatic button_irq_cycle(input logic [6:0] board, input logic [7:0] usb,
                                  input logic [6:0] exp);
    int n;
    check_value("merged model", merge_buttons(board, usb), exp);
    i_btn     = board;
    i_usb_btn = usb;
    n         = 0;
    while (o_irq_n !== 1'b0 && n < 200)
    begin
      step;
      n++;
    end
    if (o_irq_n !== 1'b0)
    begin
      timeouts++;
      $display("timed out waiting for the button interrupt");
    end
    read_reg("o_spi_rdata status", `NC_PAGE_STATUS, 8'h80);
    read_reg("o_spi_rdata buttons", 8'h00, {1'b0, exp});
    check_value("o_irq_n", o_irq_n, 1'b1);
  endtask

  task automatic joypad_readout(input logic [6:0] board, input logic [7:0] usb,
                                input logic [7:0] exp);
    check_value("pad model", board_to_pad(board, usb), exp);
    i_btn     = board;
    i_usb_btn = usb;
    step; // board levels registered
    i_joy_strobe = 1'b1;
    step;
    i_joy_strobe = 1'b0;
    for (int i = 0; i <= 8; i++)
    begin
      #1;
      check_value("o_joy_data", o_joy_data, (i < 8) ? exp[i] : 1'b0);
      step;
      if (i < 8)
      begin
        i_joy_clock = 1'b1;
        step;
        i_joy_clock = 1'b0; // shift on this falling edge
        step;
      end
    end
  endtask

  task automatic audio_duty(input logic [15:0] sample, input logic [31:0] exp_cnt);
    int cnt;
    cnt      = 0;
    i_sample = sample;
    repeat (4096)
    begin
      step;
      #1;
      if (o_audio > sample[`NC_SAMPLE_W-1 -: `NC_AUDIO_W])
        cnt++;
    end
    check_value("o_audio high count", cnt, exp_cnt);
    step;
  endtask

  initial
  begin
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    errors       = 0;
    timeouts     = 0;
    checks       = 0;
    lfsr         = 32'hc14;
    clock        = 1'b0;
    i_rst_n      = 1'b0;
    i_spi        = '0;
    i_btn        = '0;
    i_usb_btn    = '0;
    i_joy_strobe = 1'b0;
    i_joy_clock  = 1'b0;
    i_sample     = '0;
    repeat (5) @(posedge clock);
    #1;
    i_rst_n = 1'b1;
    step;
    check_value("o_load_valid", o_load_valid, 1'b0);
    check_value("o_sys_reset", o_sys_reset, 1'b0);
    check_value("o_irq_n", o_irq_n, 1'b1);
    check_value("o_joy_data", o_joy_data, 1'b0);
    check_value("o_audio", o_audio, 4'h0);
    fd = $fopen("tb/nes_ctrl_vectors.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open the vector file");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 0)
          n = $sscanf(line, "%c %h %h %h", op, f1, f2, f3);
        if (n >= 3 && op != "#")
        begin
          case (op)
            "W": write_burst(f1, f2, f3);
            "B": button_irq_cycle(f1[6:0], f2[7:0], f3[6:0]);
            "J": joypad_readout(f1[6:0], f2[7:0], f3[7:0]);
            "A": audio_duty(f1[15:0], f2);
            default:
            begin
              errors++;
              $display("unknown operation letter in the vector file");
            end
          endcase
          idle_gap;
        end
      end
      $fclose(fd);
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== nes_ctrl.f ====
+incdir+rtl
rtl/nes_ctrl_pkg.sv
rtl/spi_reg_port.sv
rtl/btn_irq_ctrl.sv
rtl/joypad_serializer.sv
rtl/audio_dither_dac.sv
rtl/nes_ctrl_top.sv
tb/nes_ctrl_assertions.sv
tb/nes_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: nes_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/nes_ctrl_pkg.sv
      - rtl/spi_reg_port.sv
      - rtl/btn_irq_ctrl.sv
      - rtl/joypad_serializer.sv
      - rtl/audio_dither_dac.sv
      - rtl/nes_ctrl_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/nes_ctrl_assertions.sv
      - tb/nes_ctrl_tb.sv

// ==== tb/nes_ctrl_vectors.txt ====
# W addr data exp_sys_reset | B board usb exp_merged | J board usb exp_pad
# A sample exp_high_count (all fields hex)
W 00001000 A5 0
W FF000000 01 1
W 12345678 3C 1
W FF000004 FE 0
W FF0000A0 03 1
B 44 00 45
B 00 30 19
B 0A 80 4B
J 4A 0D 9F
J 0B 82 92
A 3800 800
A 7123 123
A E001 001
A 1FFF FFF
